// ==== design/cart_loader_pkg.sv ====
package cart_loader_pkg;

	// ================================================
	// Widths
	// ================================================
	localparam int ADDR_W = 25;
	localparam int DATA_W = 16;
	localparam int MASK_W = 24;
	localparam int LBA_W  = 16;

	// Download index reserved for cheat codes
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	// ================================================
	// Cartridge header locations
	// ================================================
	localparam logic [ADDR_W-1:0] COPIER_SKIP = 25'h200;
	localparam logic [ADDR_W-1:0] LOROM_HDR   = 25'h7FD6;
	localparam logic [ADDR_W-1:0] HIROM_HDR   = 25'hFFD6;
	localparam logic [ADDR_W-1:0] EXHIROM_HDR = 25'h40FFD6;

	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;

	// 512-byte sectors on the storage side
	localparam int SECTOR_SHIFT = 9;

	typedef enum logic [2:0] {
		AUTO,
		NO_HEADER,
		LOROM,
		HIROM,
		EXHIROM
	} header_mode_t;

	typedef enum logic [1:0] {
		AUTO_REGION,
		NTSC,
		PAL_FORCE
	} region_mode_t;

	typedef struct packed {
		logic              valid;
		logic              is_code;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} dl_word_t;

	// Word 0 of a copier image
	typedef struct packed {
		logic [7:0] rom_type;
		logic [3:0] ram_size;
		logic [3:0] rom_size;
	} hdr_copier_t;

	// Size word inside the internal cartridge header
	typedef struct packed {
		logic [3:0] spare_hi;
		logic [3:0] rom_size;
		logic [3:0] spare_lo;
		logic [3:0] ram_size;
	} hdr_internal_t;

	typedef union packed {
		hdr_copier_t   copier;
		hdr_internal_t internal_hdr;
	} hdr_word_u;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic [7:0]        rom_type;
		logic [MASK_W-1:0] rom_mask;
		logic [MASK_W-1:0] ram_mask;
		logic              pal;
	} cart_info_t;

endpackage

// ==== design/download_router.sv ====
`timescale 1ns/1ns

module download_router import cart_loader_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              dl_active,
	input  logic              dl_wr,
	input  logic [7:0]        dl_index,
	input  logic [ADDR_W-1:0] dl_addr,
	input  logic [DATA_W-1:0] dl_data,
	output dl_word_t          word_out,
	output logic              cart_active,
	output logic              cart_start,
	output logic              cart_end
);

	logic              code_sel;
	logic              cart_now;
	logic              valid_q;
	logic              is_code_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] data_q;

	assign code_sel = (dl_index == CODE_INDEX);
	assign cart_now = dl_active & ~code_sel;

	// ================================================
	// Word register and cartridge edges
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			valid_q     <= 1'b0;
			is_code_q   <= 1'b0;
			cart_active <= 1'b0;
			cart_start  <= 1'b0;
			cart_end    <= 1'b0;
		end else begin
			valid_q     <= dl_wr;
			is_code_q   <= code_sel;
			// cart_active doubles as the previous level of cart_now
			cart_active <= cart_now;
			cart_start  <= cart_now & ~cart_active;
			cart_end    <= ~cart_now & cart_active;
		end
	end

	// Payload
	always_ff @(posedge clk_sys) begin
		addr_q <= dl_addr;
		data_q <= dl_data;
	end

	assign word_out = '{valid: valid_q, is_code: is_code_q, addr: addr_q, data: data_q};

	// The host only writes words inside a download
	a_valid_in_download: assert property (
		@(posedge clk_sys) disable iff (!reset)
		word_out.valid |-> $past(dl_active)
	);

endmodule

// ==== design/header_parser.sv ====
`timescale 1ns/1ns

module header_parser import cart_loader_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  dl_word_t     word_in,
	input  logic         cart_active,
	input  header_mode_t header_mode,
	input  region_mode_t region_mode,
	output cart_info_t   info
);

	hdr_word_u         hdr;
	logic              cart_wr;
	logic              use_internal;
	logic [ADDR_W-1:0] hdr_base;
	logic [ADDR_W-1:0] rom_size_addr;
	logic [ADDR_W-1:0] ram_size_addr;
	logic [3:0]        rom_size;
	logic [3:0]        ram_size;
	logic [7:0]        rom_type;
	logic              rom_region;
	logic              pal;

	assign hdr     = word_in.data;
	assign cart_wr = word_in.valid & ~word_in.is_code & cart_active;

	// Where the internal header lives for the selected map
	always_comb begin
		use_internal = 1'b1;
		case (header_mode)
			LOROM:   hdr_base = LOROM_HDR;
			HIROM:   hdr_base = HIROM_HDR;
			EXHIROM: hdr_base = EXHIROM_HDR;
			default: begin
				hdr_base     = LOROM_HDR;
				use_internal = 1'b0;
			end
		endcase
	end

	// Image still carries the copier block in front
	assign rom_size_addr = hdr_base + COPIER_SKIP;
	assign ram_size_addr = rom_size_addr + 25'd2;

	// ================================================
	// Header capture
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= 4'h0;
			rom_type   <= 8'h00;
			rom_region <= 1'b0;
		end else if (cart_wr) begin
			if (word_in.addr == '0) begin
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= 4'h0;
				// Copier sizes only count when the low byte is filled in
				if (header_mode == AUTO &&
				    {hdr.copier.ram_size, hdr.copier.rom_size} != 8'h00) begin
					rom_size <= hdr.copier.rom_size;
					ram_size <= hdr.copier.ram_size;
				end

				case (header_mode)
					NO_HEADER: rom_type <= 8'd0;
					LOROM:     rom_type <= 8'd0;
					HIROM:     rom_type <= 8'd1;
					EXHIROM:   rom_type <= 8'd2;
					default:   rom_type <= hdr.copier.rom_type;
				endcase
			end

			if (word_in.addr == 25'd2) begin
				rom_region <= word_in.data[8];
			end

			if (use_internal) begin
				if (word_in.addr == rom_size_addr) begin
					rom_size <= hdr.internal_hdr.rom_size;
				end
				if (word_in.addr == ram_size_addr) begin
					ram_size <= hdr.internal_hdr.ram_size;
				end
			end
		end
	end

	// ================================================
	// Video region
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			pal <= 1'b0;
		end else if (!cart_active) begin
			case (region_mode)
				AUTO_REGION: pal <= rom_region;
				NTSC:        pal <= 1'b0;
				PAL_FORCE:   pal <= 1'b1;
				default:     pal <= rom_region;
			endcase
		end
	end

	// Masks follow the size codes directly, 1 KiB per step
	assign info.rom_type = rom_type;
	assign info.rom_mask = (MASK_W'(1024) << rom_size) - MASK_W'(1);
	assign info.ram_mask = (ram_size != 4'h0) ? (MASK_W'(1024) << ram_size) - MASK_W'(1)
	                                          : '0;
	assign info.pal      = pal;

endmodule

// ==== design/cheat_assembler.sv ====
`timescale 1ns/1ns

module cheat_assembler import cart_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  dl_word_t    word_in,
	input  logic        cart_active,
	output cheat_code_t code,
	output logic        cheat_load,
	output logic        cheat_clear
);

	logic code_wr;

	assign code_wr = word_in.valid & word_in.is_code;

	// ================================================
	// Code fields, low word first within each field
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (word_in.addr[3:0])
				4'd0:  code.flags[15:0]    <= word_in.data;
				4'd2:  code.flags[31:16]   <= word_in.data;
				4'd4:  code.address[15:0]  <= word_in.data;
				4'd6:  code.address[31:16] <= word_in.data;
				4'd8:  code.compare[15:0]  <= word_in.data;
				4'd10: code.compare[31:16] <= word_in.data;
				4'd12: code.replace[15:0]  <= word_in.data;
				4'd14: code.replace[31:16] <= word_in.data;
				default: ;
			endcase
		end
	end

	// Strobes to the cheat engine
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_load  <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Last word of the group completes the code
			cheat_load  <= code_wr & (word_in.addr[3:0] == 4'd14);
			// New code file or new cartridge drops the old list
			cheat_clear <= (code_wr & (word_in.addr == '0)) | cart_active;
		end
	end

	// One load per eight-word group
	a_single_load: assert property (
		@(posedge clk_sys) disable iff (!reset)
		cheat_load |=> !cheat_load
	);

endmodule

// ==== design/backup_sequencer.sv ====
`timescale 1ns/1ns

module backup_sequencer import cart_loader_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              cart_active,
	input  logic              cart_start,
	input  logic              cart_end,
	input  logic [MASK_W-1:0] ram_mask,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic              img_nonempty,
	input  logic              save_write,
	input  logic              osd_open,
	input  logic              load_req,
	input  logic              save_req,
	input  logic              autosave,
	input  logic              sd_ack,
	output logic [LBA_W-1:0]  sd_lba,
	output logic              sd_rd,
	output logic              sd_wr,
	output logic              bk_ena,
	output logic              bk_pending,
	output logic              bk_busy,
	output logic              hold_console
);

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_REQ,
		BK_XFER
	} bk_state_t;

	bk_state_t        state;
	logic             loading;
	logic             old_load;
	logic             old_save;
	logic             old_ack;
	logic             save_raise;
	logic             start_load;
	logic             start_save;
	logic             start_cart;
	logic [LBA_W-1:0] last_lba;

	// Autosave fires once the menu is up with unsaved data
	assign save_raise = save_req | (autosave & bk_pending & osd_open);
	assign start_load = bk_ena & load_req & ~old_load;
	assign start_save = bk_ena & save_raise & ~old_save;
	assign start_cart = bk_ena & cart_end & img_nonempty;
	assign last_lba   = LBA_W'(ram_mask >> SECTOR_SHIFT);
	assign bk_busy    = (state != BK_IDLE);

	// cart_end covers the gap before the reload starts
	assign hold_console = cart_active | cart_end | (bk_busy & loading);

	// ================================================
	// Backup enable and pending save
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			if (cart_start) begin
				bk_ena <= 1'b0;
			end
			if (cart_active && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end

			if (bk_ena && !osd_open && save_write) begin
				bk_pending <= 1'b1;
			end else if (bk_busy) begin
				bk_pending <= 1'b0;
			end
		end
	end

	// ================================================
	// Sector transfer FSM
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state    <= BK_IDLE;
			loading  <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			sd_lba   <= '0;
		end else begin
			old_load <= load_req;
			old_save <= save_raise;
			old_ack  <= sd_ack;

			case (state)
				BK_IDLE: begin
					if (start_cart || start_load || start_save) begin
						// Reload after a download wins over a save
						loading <= start_cart | start_load;
						sd_rd   <= start_cart | start_load;
						sd_wr   <= ~(start_cart | start_load);
						sd_lba  <= '0;
						state   <= BK_REQ;
					end
				end
				BK_REQ: begin
					if (sd_ack && !old_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= BK_XFER;
					end
				end
				BK_XFER: begin
					// Sector done when ack drops
					if (!sd_ack && old_ack) begin
						if (sd_lba >= last_lba) begin
							loading <= 1'b0;
							state   <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= loading;
							sd_wr  <= ~loading;
							state  <= BK_REQ;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	a_rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (!reset)
		!(sd_rd && sd_wr)
	);

endmodule

// ==== design/cart_loader_top.sv ====
`timescale 1ns/1ns

module cart_loader_top import cart_loader_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              dl_active,
	input  logic [7:0]        dl_index,
	input  logic [ADDR_W-1:0] dl_addr,
	input  logic [DATA_W-1:0] dl_data,
	input  logic              dl_wr,
	input  header_mode_t      header_mode,
	input  region_mode_t      region_mode,
	input  logic              sd_ack,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic              img_nonempty,
	input  logic              save_write,
	input  logic              osd_open,
	input  logic              load_req,
	input  logic              save_req,
	input  logic              autosave,
	output logic [LBA_W-1:0]  sd_lba,
	output logic              sd_rd,
	output logic              sd_wr,
	output logic              bk_ena,
	output logic              bk_pending,
	output logic              bk_busy,
	output logic              hold_console,
	output cart_info_t        info,
	output cheat_code_t       code,
	output logic              cheat_load,
	output logic              cheat_clear
);

	dl_word_t dl_word;
	logic     cart_active;
	logic     cart_start;
	logic     cart_end;

	download_router i_download_router (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active   (dl_active),
		.dl_wr       (dl_wr),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.word_out    (dl_word),
		.cart_active (cart_active),
		.cart_start  (cart_start),
		.cart_end    (cart_end)
	);

	header_parser i_header_parser (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.word_in     (dl_word),
		.cart_active (cart_active),
		.header_mode (header_mode),
		.region_mode (region_mode),
		.info        (info)
	);

	cheat_assembler i_cheat_assembler (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.word_in     (dl_word),
		.cart_active (cart_active),
		.code        (code),
		.cheat_load  (cheat_load),
		.cheat_clear (cheat_clear)
	);

	// Save RAM size comes from the parsed header
	backup_sequencer i_backup_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_active  (cart_active),
		.cart_start   (cart_start),
		.cart_end     (cart_end),
		.ram_mask     (info.ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_nonempty (img_nonempty),
		.save_write   (save_write),
		.osd_open     (osd_open),
		.load_req     (load_req),
		.save_req     (save_req),
		.autosave     (autosave),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_ena       (bk_ena),
		.bk_pending   (bk_pending),
		.bk_busy      (bk_busy),
		.hold_console (hold_console)
	);

endmodule

// ==== tests/tb_cart_loader.sv ====
`timescale 1ns/1ns

module tb_cart_loader import cart_loader_pkg::*; ();

	logic              clk_sys;
	logic              reset;
	logic              dl_active;
	logic [7:0]        dl_index;
	logic [ADDR_W-1:0] dl_addr;
	logic [DATA_W-1:0] dl_data;
	logic              dl_wr;
	header_mode_t      header_mode;
	region_mode_t      region_mode;
	logic              sd_ack;
	logic              img_mounted;
	logic              img_readonly;
	logic              img_nonempty;
	logic              save_write;
	logic              osd_open;
	logic              load_req;
	logic              save_req;
	logic              autosave;
	logic [LBA_W-1:0]  sd_lba;
	logic              sd_rd;
	logic              sd_wr;
	logic              bk_ena;
	logic              bk_pending;
	logic              bk_busy;
	logic              hold_console;
	cart_info_t        info;
	cheat_code_t       code;
	logic              cheat_load;
	logic              cheat_clear;

	int   errors = 0;
	int   test_errors = 0;
	int   checks = 0;
	int   tests_run = 0;
	int   tests_failed = 0;
	int   read_sectors = 0;
	int   write_sectors = 0;
	int   load_pulses = 0;
	int   clear_pulses = 0;
	int   expected_sectors = 0;
	int   next_lba = 0;
	logic sector_write;

	cart_loader_top i_cart_loader_top (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.dl_wr        (dl_wr),
		.header_mode  (header_mode),
		.region_mode  (region_mode),
		.sd_ack       (sd_ack),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_nonempty (img_nonempty),
		.save_write   (save_write),
		.osd_open     (osd_open),
		.load_req     (load_req),
		.save_req     (save_req),
		.autosave     (autosave),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_ena       (bk_ena),
		.bk_pending   (bk_pending),
		.bk_busy      (bk_busy),
		.hold_console (hold_console),
		.info         (info),
		.code         (code),
		.cheat_load   (cheat_load),
		.cheat_clear  (cheat_clear)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ================================================
	// Storage model and strobe counters
	// ================================================
	initial begin
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				// Sectors of one transfer come in order from 0
				check_value("sd_lba", sd_lba, next_lba);
				next_lba++;
				sector_write = sd_wr;
				repeat (1 + $urandom % 4) @(posedge clk_sys);
				sd_ack <= 1'b1;
				repeat (2 + $urandom % 4) @(posedge clk_sys);
				sd_ack <= 1'b0;
				if (sector_write) begin
					write_sectors++;
				end else begin
					read_sectors++;
				end
			end else if (bk_busy !== 1'b1) begin
				next_lba = 0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (cheat_load === 1'b1) begin
			load_pulses <= load_pulses + 1;
		end
		if (cheat_clear === 1'b1) begin
			clear_pulses <= clear_pulses + 1;
		end
	end

	// ================================================
	// Helpers
	// ================================================
	task automatic check_value(input string name, input logic [127:0] actual,
	                           input logic [127:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			errors++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d error(s)", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic begin_download(input logic [7:0] index);
		@(posedge clk_sys);
		dl_index  <= index;
		dl_active <= 1'b1;
	endtask

	task automatic send_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(posedge clk_sys);
		dl_addr <= addr;
		dl_data <= data;
		dl_wr   <= 1'b1;
		@(posedge clk_sys);
		dl_wr   <= 1'b0;
	endtask

	// Keep the download open long enough for the RAM size to reach bk_ena
	task automatic end_download;
		repeat (3) @(posedge clk_sys);
		dl_active <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic wait_for_busy(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (bk_busy !== level && cycles < 2000) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (bk_busy !== level) begin
			$display("timeout: bk_busy never went to %0d during %s", level, what);
			errors++;
			test_errors++;
		end
	endtask

	// ================================================
	// Directed tests
	// ================================================
	task automatic auto_header;
		header_mode <= AUTO;
		begin_download(8'h00);
		send_word(25'h0, 16'h230A);
		end_download();
		repeat (4) @(negedge clk_sys);
		check_value("info.rom_type", info.rom_type, 8'h23);
		check_value("info.rom_mask", info.rom_mask, 24'h0FFFFF);
		check_value("info.ram_mask", info.ram_mask, 24'h0);

		// Empty size byte falls back to the default ROM size
		begin_download(8'h00);
		send_word(25'h0, 16'h2300);
		end_download();
		repeat (4) @(negedge clk_sys);
		check_value("info.rom_mask", info.rom_mask, 24'h3FFFFF);
		check_value("info.ram_mask", info.ram_mask, 24'h0);
		finish_test("auto header");
	endtask

	task automatic internal_header(input header_mode_t mode, input logic [ADDR_W-1:0] base,
	                               input logic [7:0] rom_type);
		@(posedge clk_sys);
		header_mode <= mode;
		begin_download(8'h00);
		send_word(25'h0, 16'h55AA);
		send_word(base + COPIER_SKIP, 16'h0900);
		send_word(base + COPIER_SKIP + 25'd2, 16'h0003);
		end_download();
		repeat (4) @(negedge clk_sys);
		check_value("info.rom_type", info.rom_type, rom_type);
		check_value("info.rom_mask", info.rom_mask, 24'h07FFFF);
		check_value("info.ram_mask", info.ram_mask, 24'h001FFF);
	endtask

	task automatic internal_headers;
		internal_header(LOROM, LOROM_HDR, 8'd0);
		internal_header(HIROM, HIROM_HDR, 8'd1);
		internal_header(EXHIROM, EXHIROM_HDR, 8'd2);
		finish_test("internal headers");
	endtask

	task automatic region_select;
		@(posedge clk_sys);
		header_mode <= NO_HEADER;
		region_mode <= AUTO_REGION;
		begin_download(8'h00);
		send_word(25'h0, 16'h0000);
		send_word(25'h2, 16'h0100);
		end_download();
		repeat (4) @(negedge clk_sys);
		check_value("info.pal auto", info.pal, 1'b1);

		@(posedge clk_sys);
		region_mode <= NTSC;
		repeat (2) @(negedge clk_sys);
		check_value("info.pal ntsc", info.pal, 1'b0);

		@(posedge clk_sys);
		region_mode <= PAL_FORCE;
		repeat (2) @(negedge clk_sys);
		check_value("info.pal forced", info.pal, 1'b1);

		@(posedge clk_sys);
		region_mode <= AUTO_REGION;
		finish_test("region select");
	endtask

	task automatic cheat_code;
		logic [15:0] words [8];
		int          loads_before;
		int          clears_before;
		words = '{16'h0004, 16'h8000, 16'h1234, 16'h007E,
		          16'h00AA, 16'h5A00, 16'h00BB, 16'hC3C3};
		loads_before  = load_pulses;
		clears_before = clear_pulses;

		begin_download(CODE_INDEX);
		send_word(25'h0, words[0]);
		repeat (3) @(negedge clk_sys);
		check_value("cheat_clear pulses", clear_pulses - clears_before, 1);
		for (int i = 1; i < 8; i++) begin
			send_word(ADDR_W'(2 * i), words[i]);
		end
		end_download();
		repeat (4) @(negedge clk_sys);

		check_value("cheat_load pulses", load_pulses - loads_before, 1);
		check_value("cheat_clear pulses", clear_pulses - clears_before, 1);
		check_value("code.flags", code.flags, {words[1], words[0]});
		check_value("code.address", code.address, {words[3], words[2]});
		check_value("code.compare", code.compare, {words[5], words[4]});
		check_value("code.replace", code.replace, {words[7], words[6]});
		finish_test("cheat code");
	endtask

	task automatic load_after_download;
		int reads_before;
		int writes_before;
		int gaps;
		int cycles;
		reads_before  = read_sectors;
		writes_before = write_sectors;
		// 8 KiB of save RAM in 512-byte sectors
		expected_sectors = 16;

		@(posedge clk_sys);
		header_mode  <= LOROM;
		img_mounted  <= 1'b1;
		img_readonly <= 1'b0;
		img_nonempty <= 1'b1;
		begin_download(8'h00);
		send_word(25'h0, 16'h0000);
		send_word(LOROM_HDR + COPIER_SKIP, 16'h0900);
		send_word(LOROM_HDR + COPIER_SKIP + 25'd2, 16'h0003);
		end_download();

		wait_for_busy(1'b1, "reload start");
		gaps   = 0;
		cycles = 0;
		while (bk_busy === 1'b1 && cycles < 2000) begin
			if (hold_console !== 1'b1) begin
				gaps++;
			end
			@(negedge clk_sys);
			cycles++;
		end
		if (bk_busy === 1'b1) begin
			$display("timeout: reload after download never finished");
			errors++;
			test_errors++;
		end

		@(negedge clk_sys);
		check_value("hold_console low cycles", gaps, 0);
		check_value("hold_console", hold_console, 1'b0);
		check_value("read sectors", read_sectors - reads_before, expected_sectors);
		check_value("write sectors", write_sectors - writes_before, 0);
		check_value("bk_ena", bk_ena, 1'b1);
		finish_test("load after download");
	endtask

	task automatic autosave_and_reload;
		int reads_before;
		int writes_before;
		@(posedge clk_sys);
		save_write <= 1'b1;
		@(posedge clk_sys);
		save_write <= 1'b0;
		repeat (2) @(negedge clk_sys);
		check_value("bk_pending", bk_pending, 1'b1);

		// Menu opens with unsaved data
		reads_before  = read_sectors;
		writes_before = write_sectors;
		@(posedge clk_sys);
		autosave <= 1'b1;
		osd_open <= 1'b1;
		wait_for_busy(1'b1, "autosave start");
		wait_for_busy(1'b0, "autosave end");
		@(negedge clk_sys);
		check_value("write sectors", write_sectors - writes_before, expected_sectors);
		check_value("read sectors", read_sectors - reads_before, 0);
		check_value("bk_pending", bk_pending, 1'b0);

		@(posedge clk_sys);
		osd_open <= 1'b0;
		autosave <= 1'b0;

		// Manual reload
		reads_before  = read_sectors;
		writes_before = write_sectors;
		@(posedge clk_sys);
		load_req <= 1'b1;
		repeat (2) @(posedge clk_sys);
		load_req <= 1'b0;
		wait_for_busy(1'b1, "manual load start");
		wait_for_busy(1'b0, "manual load end");
		@(negedge clk_sys);
		check_value("read sectors", read_sectors - reads_before, expected_sectors);
		check_value("write sectors", write_sectors - writes_before, 0);
		check_value("bk_pending", bk_pending, 1'b0);
		finish_test("autosave and reload");
	endtask

	// ================================================
	// Sequence
	// ================================================
	initial begin
		void'($urandom(54654));
		reset        = 1'b0;
		dl_active    = 1'b0;
		dl_index     = 8'h00;
		dl_addr      = '0;
		dl_data      = '0;
		dl_wr        = 1'b0;
		header_mode  = AUTO;
		region_mode  = AUTO_REGION;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_nonempty = 1'b0;
		save_write   = 1'b0;
		osd_open     = 1'b0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		autosave     = 1'b0;

		repeat (3) @(posedge clk_sys);
		reset <= 1'b1;
		repeat (2) @(posedge clk_sys);

		auto_header();
		internal_headers();
		region_select();
		cheat_code();
		load_after_download();
		autosave_and_reload();

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
		         tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
design/cart_loader_pkg.sv
design/download_router.sv
design/header_parser.sv
design/cheat_assembler.sv
design/backup_sequencer.sv
design/cart_loader_top.sv
tests/tb_cart_loader.sv

// ==== Makefile ====
TOP := tb_cart_loader

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f list.f -o sim_cart_loader
	@out="$$(./obj_dir/sim_cart_loader)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing --top-module cart_loader_top -f list.f

clean:
	rm -rf obj_dir
